/* Makefile */
VERILATOR ?= verilator
TOP       ?= bnn_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* bnn_core/bnn_class_select.sv */
module bnn_class_select (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              en,
  input  logic                              data_in_ready,
  input  logic                              score_valid,
  input  logic [bnn_pkg::score_bits-1:0]    score,
  input  logic [bnn_pkg::result_bits-1:0]   score_class,
  input  bnn_pkg::core_op_t                 op,
  output logic [bnn_pkg::result_bits-1:0]   result,
  output logic                              data_out_ready
);

  logic [bnn_pkg::score_bits-1:0] best_score;

  // ------------------------------------------------------------------------
  // Running argmax
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      best_score     <= '0;
      result         <= '0;
      data_out_ready <= 1'b0;
    end else if (en) begin
      if (!data_in_ready) begin
        best_score     <= '0;
        result         <= '0;
        data_out_ready <= 1'b0;
      end else begin
        // Strictly greater only, so a tie keeps the lower class
        if (score_valid && (score > best_score || score_class == '0)) begin
          best_score <= score;
          result     <= score_class;
        end
        if (op == bnn_pkg::OP_FINISH) begin
          data_out_ready <= 1'b1;
        end
      end
    end
  end

endmodule

/* bnn_core/bnn_row_accumulate.sv */
module bnn_row_accumulate (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              en,
  input  bnn_pkg::core_op_t                 op,
  input  logic [bnn_pkg::result_bits-1:0]   class_idx,
  input  logic [4:0]                        row_idx,
  input  logic [bnn_pkg::img_bits-1:0]      img,
  output logic                              score_valid,
  output logic [bnn_pkg::score_bits-1:0]    score,
  output logic [bnn_pkg::result_bits-1:0]   score_class
);

  // Weight ROM with one 900-bit vector per class
  logic [bnn_pkg::img_bits-1:0] weights [bnn_pkg::classes];

  initial begin
    $readmemh("bnn_core/bnn_weights.mem", weights);
  end

  logic [bnn_pkg::row_bits-1:0]   img_row;
  logic [bnn_pkg::row_bits-1:0]   wgt_row;
  logic [bnn_pkg::row_bits-1:0]   match;
  logic [bnn_pkg::score_bits-1:0] row_count;
  logic [bnn_pkg::score_bits-1:0] acc;

  function automatic logic [bnn_pkg::score_bits-1:0] popcount(
    input logic [bnn_pkg::row_bits-1:0] v
  );
    logic [bnn_pkg::score_bits-1:0] n;
    n = '0;
    for (int i = 0; i < bnn_pkg::row_bits; i++) begin
      n = n + v[i];
    end
    return n;
  endfunction

  // ------------------------------------------------------------------------
  // XNOR and popcount of the current row
  // ------------------------------------------------------------------------
  assign img_row   = img[row_idx * bnn_pkg::row_bits +: bnn_pkg::row_bits];
  assign wgt_row   = weights[class_idx][row_idx * bnn_pkg::row_bits +: bnn_pkg::row_bits];
  assign match     = ~(img_row ^ wgt_row);
  assign row_count = popcount(match);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      score_valid <= 1'b0;
    end else if (en) begin
      score_valid <= (op == bnn_pkg::OP_LAST_ROW);
    end
  end

  // Per-class score accumulation
  always_ff @(posedge clk) begin
    if (en) begin
      case (op)
        bnn_pkg::OP_FIRST_ROW: acc <= row_count;
        bnn_pkg::OP_NEXT_ROW:  acc <= acc + row_count;
        bnn_pkg::OP_LAST_ROW: begin
          score       <= acc + row_count;
          score_class <= class_idx;
        end
        default: ;
      endcase
    end
  end

endmodule

/* bnn_core/bnn_row_sequencer.sv */
module bnn_row_sequencer (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              en,
  input  logic                              data_in_ready,
  output bnn_pkg::core_op_t                 op,
  output logic [bnn_pkg::result_bits-1:0]   class_idx,
  output logic [4:0]                        row_idx
);

  logic busy;
  logic finish_pend;
  logic din_q;

  // ------------------------------------------------------------------------
  // Row and class walk
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy        <= 1'b0;
      finish_pend <= 1'b0;
      din_q       <= 1'b0;
      class_idx   <= '0;
      row_idx     <= '0;
    end else if (en) begin
      din_q       <= data_in_ready;
      finish_pend <= 1'b0;
      if (!data_in_ready) begin
        // Dropped start aborts any run
        busy <= 1'b0;
      end else if (!din_q) begin
        busy      <= 1'b1;
        class_idx <= '0;
        row_idx   <= '0;
      end else if (busy) begin
        if (row_idx == 5'(bnn_pkg::rows - 1)) begin
          row_idx <= '0;
          if (class_idx == 4'(bnn_pkg::classes - 1)) begin
            busy        <= 1'b0;
            finish_pend <= 1'b1;
          end else begin
            class_idx <= class_idx + 1'b1;
          end
        end else begin
          row_idx <= row_idx + 1'b1;
        end
      end
    end
  end

  // Opcode for the current step
  always_comb begin
    op = bnn_pkg::OP_NONE;
    if (data_in_ready) begin
      if (busy) begin
        if (row_idx == '0) begin
          op = bnn_pkg::OP_FIRST_ROW;
        end else if (row_idx == 5'(bnn_pkg::rows - 1)) begin
          op = bnn_pkg::OP_LAST_ROW;
        end else begin
          op = bnn_pkg::OP_NEXT_ROW;
        end
      end else if (finish_pend) begin
        op = bnn_pkg::OP_FINISH;
      end
    end
  end

endmodule

/* bnn_core/bnn_top.sv */
module bnn_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              en,
  input  logic [bnn_pkg::img_bits-1:0]      img,
  input  logic                              data_in_ready,
  output logic [bnn_pkg::result_bits-1:0]   result,
  output logic                              data_out_ready
);

  bnn_pkg::core_op_t              op;
  logic [bnn_pkg::result_bits-1:0] class_idx;
  logic [4:0]                      row_idx;
  logic                            score_valid;
  logic [bnn_pkg::score_bits-1:0]  score;
  logic [bnn_pkg::result_bits-1:0] score_class;

  // Decode
  bnn_row_sequencer u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .en            (en),
    .data_in_ready (data_in_ready),
    .op            (op),
    .class_idx     (class_idx),
    .row_idx       (row_idx)
  );

  // Execute
  bnn_row_accumulate u_acc (
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .op          (op),
    .class_idx   (class_idx),
    .row_idx     (row_idx),
    .img         (img),
    .score_valid (score_valid),
    .score       (score),
    .score_class (score_class)
  );

  // Result
  bnn_class_select u_sel (
    .clk            (clk),
    .rst_n          (rst_n),
    .en             (en),
    .data_in_ready  (data_in_ready),
    .score_valid    (score_valid),
    .score          (score),
    .score_class    (score_class),
    .op             (op),
    .result         (result),
    .data_out_ready (data_out_ready)
  );

endmodule

/* bnn_core/bnn_weights.mem */
// One 900-bit weight vector per line in hex, most significant digit first
// Line n holds class n, class 0 on the first data line
3a7f19c04be2d583a7f19c04be2d583a7f19c04be2d583a7f19c04be2d583a7f19c04be2d583a7f19c04be2d583a7f19c04be2d583a7f19c04be2d583a7f19c04be2d583a7f19c04be2d583a7f19c04be2d583a7f19c04be2d583a7f19c04be2d583a7f19c04be2d583a7f19c04be2d58
e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5e91c6b2f07d43a5
5d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b25d08f3a9c61e7b2
b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83b46e2d917fa0c83
07c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f16407c5a83e2b9f164
9f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a359f2b74d1e0c6a35
6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d6a93c0f57e18b2d
d1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07cd1e48b2a693f07c
2c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e82c7d5f6091ab4e8
8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa8b3019e7d42c6fa

/* common/bnn_pkg.sv */
package bnn_pkg;

  // ------------------------------------------------------------------------
  // Image and network sizes
  // ------------------------------------------------------------------------
  localparam int img_bits = 900;
  localparam int row_bits = 30;
  localparam int rows     = 30;
  localparam int classes  = 10;

  // Class index and score widths
  localparam int result_bits = 4;
  localparam int score_bits  = 10;

  // Reported for an all-zero image
  localparam logic [result_bits-1:0] blank_result = 4'd10;

  // One enable every four clk cycles
  localparam int clk_div_bits = 2;

  // ------------------------------------------------------------------------
  // Enums
  // ------------------------------------------------------------------------
  // Host side control states
  typedef enum logic [1:0] {
    IDLE,
    INFERENCE,
    DONE
  } host_state_t;

  // Per-step work issued by the row sequencer
  typedef enum logic [2:0] {
    OP_NONE,
    OP_FIRST_ROW,
    OP_NEXT_ROW,
    OP_LAST_ROW,
    OP_FINISH
  } core_op_t;

endpackage

/* files.f */
common/bnn_pkg.sv
bnn_core/bnn_row_sequencer.sv
bnn_core/bnn_row_accumulate.sv
bnn_core/bnn_class_select.sv
bnn_core/bnn_top.sv
logic/bnn_interface.sv
testbench/bnn_assert.sv
testbench/bnn_tb.sv

/* logic/bnn_interface.sv */
module bnn_interface (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [bnn_pkg::img_bits-1:0]      img_in,
  input  logic                              bnn_enable,
  input  logic                              bnn_clear,
  output logic [bnn_pkg::result_bits-1:0]   result_out,
  output logic                              result_ready
);

  logic [bnn_pkg::clk_div_bits-1:0] clk_div;
  logic                             en;

  logic start_lvl;
  logic start_sync1;
  logic start_sync2;
  logic h2b_pulse;

  logic core_done;
  logic done_sync1;
  logic done_sync2;

  logic [bnn_pkg::result_bits-1:0] core_result;
  logic [bnn_pkg::result_bits-1:0] result_q;
  logic [bnn_pkg::img_bits-1:0]    img_q;

  bnn_pkg::host_state_t state;
  bnn_pkg::host_state_t next_state;

  // ------------------------------------------------------------------------
  // Divide-by-4 step enable for the core
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clk_div <= '0;
    end else begin
      clk_div <= clk_div + 1'b1;
    end
  end

  assign en = (clk_div == '0);

  // ------------------------------------------------------------------------
  // Start level and handshake synchronizers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_lvl <= 1'b0;
    end else if (bnn_clear) begin
      start_lvl <= 1'b0;
    end else if (state == bnn_pkg::IDLE && bnn_enable) begin
      start_lvl <= 1'b1;
    end else if (done_sync2) begin
      start_lvl <= 1'b0;
    end
  end

  // Start goes out on enabled steps
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_sync1 <= 1'b0;
      start_sync2 <= 1'b0;
    end else if (en) begin
      start_sync1 <= start_lvl;
      start_sync2 <= start_sync1;
    end
  end

  assign h2b_pulse = start_sync1 & ~start_sync2;

  // Done comes back on every clk
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_sync1 <= 1'b0;
      done_sync2 <= 1'b0;
    end else begin
      done_sync1 <= core_done;
      done_sync2 <= done_sync1;
    end
  end

  bnn_top u_bnn_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .en             (en),
    .img            (img_q),
    .data_in_ready  (start_sync2),
    .result         (core_result),
    .data_out_ready (core_done)
  );

  // ------------------------------------------------------------------------
  // Host FSM
  // ------------------------------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      bnn_pkg::IDLE:      if (h2b_pulse) next_state = bnn_pkg::INFERENCE;
      bnn_pkg::INFERENCE: if (done_sync2) next_state = bnn_pkg::DONE;
      bnn_pkg::DONE:      next_state = bnn_pkg::DONE;
      default:            next_state = bnn_pkg::IDLE;
    endcase
    if (bnn_clear) begin
      next_state = bnn_pkg::IDLE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= bnn_pkg::IDLE;
      result_ready <= 1'b0;
      img_q        <= '0;
    end else begin
      state <= next_state;
      if (bnn_clear) begin
        result_ready <= 1'b0;
        img_q        <= '0;
      end else begin
        if (state == bnn_pkg::IDLE && h2b_pulse) begin
          img_q <= img_in;
        end
        // Held through DONE until a clear
        if (state == bnn_pkg::INFERENCE && done_sync2) begin
          result_ready <= 1'b1;
        end
      end
    end
  end

  // Core result is stable while its done level is high
  always_ff @(posedge clk) begin
    if (state == bnn_pkg::INFERENCE && done_sync2) begin
      result_q <= core_result;
    end
  end

  // Blank image override
  assign result_out = (|img_q) ? result_q : bnn_pkg::blank_result;

endmodule

/* testbench/bnn_assert.sv */
module host_control_assert (
  input logic                              clk,
  input logic                              rst_n,
  input logic                              bnn_clear,
  input logic                              result_ready,
  input logic [bnn_pkg::result_bits-1:0]   result_out,
  input logic [bnn_pkg::img_bits-1:0]      img_q,
  input bnn_pkg::host_state_t              state
);

  // Clear drops the result on the next clk
  clear_drops_ready: assert property (
    @(posedge clk) disable iff (!rst_n) bnn_clear |=> !result_ready
  ) else $error("result_ready still high in the cycle after bnn_clear");

  // Result held in DONE until a clear
  done_holds_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
      (state == bnn_pkg::DONE && !bnn_clear) |=> result_ready
  ) else $error("result_ready fell in DONE without bnn_clear");

  // Stored image is empty in IDLE and the blank code shows
  blank_image_result: assert property (
    @(posedge clk) disable iff (!rst_n)
      (state == bnn_pkg::IDLE) |-> (img_q == '0 && result_out == bnn_pkg::blank_result)
  ) else $error("stored image not empty or result_out not the blank code in IDLE");

endmodule

bind bnn_interface host_control_assert u_host_control_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .bnn_clear    (bnn_clear),
  .result_ready (result_ready),
  .result_out   (result_out),
  .img_q        (img_q),
  .state        (state)
);

/* testbench/bnn_tb.sv */
module bnn_tb;

  logic                              clk = 1'b0;
  logic                              rst_n;
  logic [bnn_pkg::img_bits-1:0]      img_in;
  logic                              bnn_enable;
  logic                              bnn_clear;
  logic [bnn_pkg::result_bits-1:0]   result_out;
  logic                              result_ready;

  logic [bnn_pkg::img_bits-1:0] weights [bnn_pkg::classes];

  integer seed;
  int     errors;
  int     checks;
  int     cycles;
  int     cycle_limit;
  logic   ready_seen;

  // Expected results in the order the inferences finish
  logic [bnn_pkg::result_bits-1:0] exp_q[$];
  string                           name_q[$];

  int                              tie_a;
  int                              tie_b;
  logic [bnn_pkg::img_bits-1:0]    work_img;
  logic [bnn_pkg::result_bits-1:0] held;
  logic                            hold_ok;
  logic                            idle_ok;

  bnn_interface uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .img_in       (img_in),
    .bnn_enable   (bnn_enable),
    .bnn_clear    (bnn_clear),
    .result_out   (result_out),
    .result_ready (result_ready)
  );

  always #2 clk = ~clk;

  // ------------------------------------------------------------------------
  // Reference model and helpers
  // ------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // Argmax of matching bit counts, first class wins a tie
  function automatic logic [bnn_pkg::result_bits-1:0] ref_classify(
    input logic [bnn_pkg::img_bits-1:0] image
  );
    int best;
    int best_score;
    int score;
    if (image == '0) begin
      return bnn_pkg::blank_result;
    end
    best       = 0;
    best_score = -1;
    for (int c = 0; c < bnn_pkg::classes; c++) begin
      score = $countones(~(image ^ weights[c]));
      if (score > best_score) begin
        best_score = score;
        best       = c;
      end
    end
    return best[bnn_pkg::result_bits-1:0];
  endfunction

  function automatic logic [bnn_pkg::img_bits-1:0] random_image();
    logic [29*32-1:0] words;
    for (int i = 0; i < 29; i++) begin
      words[i*32 +: 32] = $random(seed);
    end
    return words[bnn_pkg::img_bits-1:0];
  endfunction

  // Differing bits alternate between the two classes
  function automatic logic [bnn_pkg::img_bits-1:0] tie_image(input int a, input int b);
    logic [bnn_pkg::img_bits-1:0] v;
    bit                           pick_b;
    v      = weights[a];
    pick_b = 1'b0;
    for (int i = 0; i < bnn_pkg::img_bits; i++) begin
      if (weights[a][i] != weights[b][i]) begin
        if (pick_b) begin
          v[i] = weights[b][i];
        end
        pick_b = !pick_b;
      end
    end
    return v;
  endfunction

  task automatic start_image(input logic [bnn_pkg::img_bits-1:0] image);
    @(posedge clk);
    img_in     <= image;
    bnn_enable <= 1'b1;
    @(posedge clk);
    bnn_enable <= 1'b0;
  endtask

  // Clear, then result_ready low and the blank code on the next cycle
  task automatic clear_host(input string name);
    @(posedge clk);
    bnn_clear <= 1'b1;
    @(posedge clk);
    bnn_clear <= 1'b0;
    @(negedge clk);
    check_value({name, "_ready"}, 32'd0, 32'(result_ready));
    check_value({name, "_result"}, 32'(bnn_pkg::blank_result), 32'(result_out));
    repeat (40) @(posedge clk);
  endtask

  task automatic classify(input string name, input logic [bnn_pkg::img_bits-1:0] image);
    exp_q.push_back(ref_classify(image));
    name_q.push_back(name);
    start_image(image);
    while (!result_ready) begin
      @(negedge clk);
    end
    repeat (40) @(posedge clk);
    clear_host({name, "_clear"});
  endtask

  // ------------------------------------------------------------------------
  // Result compare and timeout
  // ------------------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n && result_ready && !ready_seen) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("result_ready rose with no inference pending");
      end else begin
        check_value(name_q.pop_front(), 32'(exp_q.pop_front()), 32'(result_out));
      end
    end
    ready_seen = result_ready;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, result_ready never arrived", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  initial begin
    seed        = 32'h5b609ac3;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    cycle_limit = 40000;
    ready_seen  = 1'b0;
    rst_n       = 1'b0;
    img_in      = '0;
    bnn_enable  = 1'b0;
    bnn_clear   = 1'b0;
    $readmemh("bnn_core/bnn_weights.mem", weights);

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    idle_ok = 1'b1;
    repeat (100) begin
      @(negedge clk);
      if (result_ready !== 1'b0 || result_out !== bnn_pkg::blank_result) begin
        idle_ok = 1'b0;
      end
    end
    check_value("reset_idle", 32'd1, 32'(idle_ok));

    for (int i = 0; i < 16; i++) begin
      classify($sformatf("random_%0d", i), random_image());
    end

    classify("blank", '0);

    // Weight vectors themselves, then an exact tie between two classes
    classify("class_3_image", weights[3]);
    classify("class_7_image", weights[7]);
    tie_a = 0;
    tie_b = 0;
    for (int a = 0; a < bnn_pkg::classes; a++) begin
      for (int b = a + 1; b < bnn_pkg::classes; b++) begin
        if (tie_b == 0 && $countones(weights[a] ^ weights[b]) % 2 == 0) begin
          tie_a = a;
          tie_b = b;
        end
      end
    end
    classify($sformatf("tie_%0d_%0d", tie_a, tie_b), tie_image(tie_a, tie_b));

    // Result held in DONE, enable pulses ignored
    work_img = random_image();
    exp_q.push_back(ref_classify(work_img));
    name_q.push_back("hold");
    start_image(work_img);
    while (!result_ready) begin
      @(negedge clk);
    end
    held    = result_out;
    hold_ok = 1'b1;
    for (int i = 0; i < 500; i++) begin
      @(posedge clk);
      bnn_enable <= (i % 50 == 10);
      @(negedge clk);
      if (result_ready !== 1'b1 || result_out !== held) begin
        hold_ok = 1'b0;
      end
    end
    check_value("hold_stable", 32'd1, 32'(hold_ok));
    clear_host("hold_clear");

    // Abort partway, only the second image may report
    start_image(random_image());
    repeat (400) @(posedge clk);
    clear_host("abort_clear");
    classify("abort_new", random_image());

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
